// File: project.f
+incdir+verilog
+incdir+tb
verilog/rv_core_pkg.sv
verilog/rv_decoder.sv
verilog/rv_alu.sv
verilog/rv_regfile.sv
verilog/rv_lsu.sv
verilog/rv_ctrl_fsm.sv
verilog/rv_core_top.sv
tb/tb_rv_core.sv

// File: tb/rv_iss_model.svh
`ifndef RV_ISS_MODEL_SVH
`define RV_ISS_MODEL_SVH

// architectural state of the reference model
rv_core_pkg::word_t ref_mem [MEM_WORDS];
rv_core_pkg::word_t ref_x [32];
rv_core_pkg::word_t ref_pc;
logic               ref_halt;
int                 mismatch_cnt = 0;
int                 fail_cnt = 0;

function automatic int mem_index(rv_core_pkg::word_t a);
  return int'(((a - `RV_RESET_VECTOR) >> 2) & (MEM_WORDS - 1)); // wraps inside the array
endfunction

task automatic check_word(string name, rv_core_pkg::word_t got, rv_core_pkg::word_t exp);
  if (got !== exp) begin
    mismatch_cnt++;
    $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
  end
endtask

task automatic check_strb(string name, rv_core_pkg::strb_t got, rv_core_pkg::strb_t exp);
  if (got !== exp) begin
    mismatch_cnt++;
    $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, exp);
  end
endtask

task automatic check_bit(string name, logic got, logic exp);
  if (got !== exp) begin
    mismatch_cnt++;
    $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, exp);
  end
endtask

task automatic report_failure(string what);
  fail_cnt++;
  $display("ERROR at %0t: %s", $time, what);
endtask

// executes the instruction at ref_pc, reports the data transfer it causes
function void iss_step(output logic xfer, output logic wr, output rv_core_pkg::word_t addr,
                       output rv_core_pkg::word_t data, output rv_core_pkg::strb_t strb);
  rv_core_pkg::word_t ins, a, b, op2, res, npc, ea, sh;
  rv_core_pkg::word_t imm_i, imm_s, imm_b, imm_j;
  logic [2:0]         f3;
  logic               wen, take;
  ins   = ref_mem[mem_index(ref_pc)];
  f3    = ins[14:12];
  a     = ref_x[ins[19:15]];
  b     = ref_x[ins[24:20]];
  imm_i = {{20{ins[31]}}, ins[31:20]};
  imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
  imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
  imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
  npc   = ref_pc + 4;
  {xfer, wr, addr, data, strb} = '0;
  wen   = 1'b1;
  res   = '0;
  case (ins[6:0])
    7'h37: res = {ins[31:12], 12'h0};             // lui
    7'h17: res = ref_pc + {ins[31:12], 12'h0};    // auipc
    7'h6f: begin
      res = ref_pc + 4;
      npc = ref_pc + imm_j;
    end
    7'h67: begin
      res = ref_pc + 4;
      npc = (a + imm_i) & ~32'h1;
    end
    7'h63: begin
      wen = 1'b0;
      case (f3)
        3'd0: take = (a == b);
        3'd1: take = (a != b);
        3'd4: take = ($signed(a) < $signed(b));
        3'd5: take = ($signed(a) >= $signed(b));
        3'd6: take = (a < b);
        3'd7: take = (a >= b);
        default: take = 1'b0;
      endcase
      if (take) npc = ref_pc + imm_b;
    end
    7'h03: begin
      ea = a + imm_i;
      sh = ref_mem[mem_index(ea)] >> {ea[1:0], 3'b000};
      case (f3)
        3'd0: res = {{24{sh[7]}}, sh[7:0]};
        3'd1: res = {{16{sh[15]}}, sh[15:0]};
        3'd4: res = {24'h0, sh[7:0]};
        3'd5: res = {16'h0, sh[15:0]};
        default: res = sh;
      endcase
      xfer = 1'b1;
      addr = ea;
    end
    7'h23: begin
      wen  = 1'b0;
      ea   = a + imm_s;
      strb = (f3 == 3'd0) ? 4'b0001 << ea[1:0] : (f3 == 3'd1) ? 4'b0011 << ea[1:0] : 4'b1111;
      data = b << {ea[1:0], 3'b000}; // bytes moved to their lanes
      for (int i = 0; i < 4; i++)
        if (strb[i]) ref_mem[mem_index(ea)][8*i +: 8] = data[8*i +: 8];
      {xfer, wr, addr} = {1'b1, 1'b1, ea};
    end
    7'h13, 7'h33: begin
      op2 = (ins[6:0] == 7'h13) ? imm_i : b;
      case (f3)
        3'd0: res = (ins[6:0] == 7'h33 && ins[30]) ? a - b : a + op2;
        3'd1: res = a << op2[4:0];
        3'd2: res = {31'h0, $signed(a) < $signed(op2)};
        3'd3: res = {31'h0, a < op2};
        3'd4: res = a ^ op2;
        3'd5: begin
          if (ins[30]) res = $signed(a) >>> op2[4:0]; // sign bits shifted in
          else res = a >> op2[4:0];
        end
        3'd6: res = a | op2;
        default: res = a & op2;
      endcase
    end
    7'h73: begin
      wen      = 1'b0;
      ref_halt = 1'b1;
    end
    default: wen = 1'b0; // unknown opcode is skipped
  endcase
  if (wen && ins[11:7] != 5'd0) ref_x[ins[11:7]] = res;
  ref_pc = npc;
endfunction

`endif

// File: tb/tb_rv_core.sv
`timescale 1ns/10ps

`include "rv_core_settings.svh"

module tb_rv_core;

  localparam int MEM_WORDS = 1024;

  logic clk, arst_n, psel, penable, pwrite, pready, halted, random_wait;
  logic [2:0] pprot;
  rv_core_pkg::word_t paddr, pwdata, prdata;
  rv_core_pkg::strb_t pstrb;
  rv_core_pkg::word_t mem [MEM_WORDS];
  rv_core_pkg::word_t prog [$];
  integer seed = 32'hef12_f115;
  int nsave = 0;
  logic exp_xfer, exp_wr, hold_chk, h_psel, h_pen, h_pwrite;
  rv_core_pkg::word_t exp_addr, exp_data, h_paddr, h_pwdata;
  rv_core_pkg::strb_t exp_strb, h_pstrb;
  logic [2:0] h_pprot;

  `include "rv_iss_model.svh"

  rv_core_top i_dut (
    .clk, .arst_n, .paddr, .psel, .penable, .pwrite, .pwdata, .pstrb, .pprot,
    .prdata, .pready, .halted
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic rv_core_pkg::word_t enc_i(logic [11:0] imm, logic [4:0] rs1,
                                               logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_core_pkg::word_t enc_s(logic [11:0] imm, logic [4:0] rs2,
                                               logic [4:0] rs1, logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic rv_core_pkg::word_t enc_b(logic [12:0] imm, logic [4:0] rs2,
                                               logic [4:0] rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  task automatic load_const(logic [4:0] rd, rv_core_pkg::word_t v);
    rv_core_pkg::word_t hi;
    hi = (v + 32'h800) >> 12; // addi below sign-extends its low part
    prog.push_back({hi[19:0], rd, 7'h37});
    prog.push_back(enc_i(v[11:0], rd, 3'd0, rd, 7'h13));
  endtask

  // rotating sw, sh and sb into the result area at x31
  task automatic save_reg(logic [4:0] r);
    logic [11:0] off;
    off = nsave * 4;
    case (nsave % 3)
      0: prog.push_back(enc_s(off, r, 5'd31, 3'd2));
      1: prog.push_back(enc_s(off + 2, r, 5'd31, 3'd1));
      default: prog.push_back(enc_s(off + (nsave % 4), r, 5'd31, 3'd0));
    endcase
    nsave++;
  endtask

  task automatic build_program();
    logic [11:0] ld_imm [10] = '{0, 1, 3, 4, 6, 10, 10, 13, 13, 15};
    logic [2:0]  ld_f3 [10] = '{2, 0, 4, 1, 5, 1, 5, 0, 4, 0};
    logic [2:0]  br_f3 [6] = '{0, 1, 4, 5, 6, 7};
    load_const(31, 32'h8000_0800);
    load_const(30, 32'h8000_0c00);
    load_const(1, $random(seed));
    load_const(2, $random(seed));
    load_const(3, $random(seed));
    for (int f = 0; f < 8; f++) begin
      prog.push_back({7'h00, 5'd2, 5'd1, 3'(f), 5'd5, 7'h33});
      save_reg(5);
    end
    prog.push_back({7'h20, 5'd2, 5'd1, 3'd0, 5'd5, 7'h33}); // sub
    save_reg(5);
    prog.push_back({7'h20, 5'd3, 5'd1, 3'd5, 5'd5, 7'h33}); // sra
    save_reg(5);
    foreach (br_f3[k]) begin
      if (br_f3[k] != 1 && br_f3[k] != 5) begin
        prog.push_back(enc_i($random(seed), 1, br_f3[k], 5, 7'h13));
      end else begin
        prog.push_back(enc_i({br_f3[k] == 5 ? 7'h20 : 7'h00, 5'($random(seed))}, 1,
                             br_f3[k], 5, 7'h13));
      end
      save_reg(5);
    end
    prog.push_back(enc_i({7'h00, 5'd7}, 5'd1, 3'd5, 5'd5, 7'h13)); // srli
    save_reg(5);
    prog.push_back(enc_i($random(seed), 5'd1, 3'd2, 5'd5, 7'h13)); // slti
    save_reg(5);
    prog.push_back(enc_i($random(seed), 5'd1, 3'd3, 5'd5, 7'h13)); // sltiu
    save_reg(5);
    prog.push_back({20'($random(seed)), 5'd5, 7'h17});
    save_reg(5);
    foreach (br_f3[k]) begin
      for (int r = 1; r <= 2; r++) begin
        prog.push_back(enc_i(12'd7, 5'd0, 3'd0, 5'd6, 7'h13));
        prog.push_back(enc_b(13'd8, 5'(r), 5'd1, br_f3[k])); // skips the next addi
        prog.push_back(enc_i(12'd9, 5'd0, 3'd0, 5'd6, 7'h13));
        save_reg(6);
      end
    end
    prog.push_back({1'b0, 10'd4, 1'b0, 8'd0, 5'd7, 7'h6f}); // jal x7, +8
    prog.push_back(enc_i(12'd0, 5'd0, 3'd0, 5'd7, 7'h13));
    save_reg(7);
    prog.push_back({20'd0, 5'd8, 7'h17});
    prog.push_back(enc_i(12'd12, 5'd8, 3'd0, 5'd9, 7'h67)); // jalr x9, 12(x8)
    prog.push_back(enc_i(12'd0, 5'd0, 3'd0, 5'd9, 7'h13));
    save_reg(9);
    save_reg(8);
    prog.push_back(enc_s(12'd0, 5'd1, 5'd30, 3'd2));
    prog.push_back(enc_s(12'd4, 5'd2, 5'd30, 3'd1));
    prog.push_back(enc_s(12'd10, 5'd1, 5'd30, 3'd1));
    prog.push_back(enc_s(12'd13, 5'd2, 5'd30, 3'd0));
    prog.push_back(enc_s(12'd15, 5'd1, 5'd30, 3'd0));
    foreach (ld_imm[k]) begin
      prog.push_back(enc_i(ld_imm[k], 5'd30, ld_f3[k], 5'd10, 7'h03));
      save_reg(10);
    end
    prog.push_back(32'h0010_0073); // ebreak
  endtask

  task automatic load_memories();
    rv_core_pkg::word_t a;
    for (int i = 0; i < MEM_WORDS; i++) begin
      a = `RV_RESET_VECTOR + 4 * i;
      mem[i] = a ^ {a[15:0], a[31:16]} ^ 32'h3c5a_a5c3;
    end
    foreach (prog[i]) mem[i] = prog[i];
    ref_mem  = mem;
    ref_x    = '{default: '0};
    ref_pc   = `RV_RESET_VECTOR;
    ref_halt = 1'b0;
    exp_xfer = 1'b0;
  endtask

  // apb slave, pready and prdata change 1 ns after the edge
  always @(posedge clk) begin
    #1;
    prdata = mem[mem_index(paddr)];
    pready = random_wait ? (($random(seed) & 3) != 0) : 1'b1;
  end

  always @(negedge clk) begin
    if (psel && penable && pready && pwrite)
      for (int i = 0; i < 4; i++)
        if (pstrb[i]) mem[mem_index(paddr)][8*i +: 8] = pwdata[8*i +: 8];
  end

  task automatic check_setup();
    rv_core_pkg::word_t mask;
    if (ref_halt) begin
      report_failure("transfer started after ebreak");
    end else if (exp_xfer) begin
      mask = {{8{exp_strb[3]}}, {8{exp_strb[2]}}, {8{exp_strb[1]}}, {8{exp_strb[0]}}};
      check_bit("pprot[2]", pprot[2], 1'b0);
      check_word("paddr", paddr, {exp_addr[31:2], 2'b00});
      check_bit("pwrite", pwrite, exp_wr);
      check_strb("pstrb", pstrb, exp_strb);
      if (exp_wr) check_word("pwdata", pwdata & mask, exp_data & mask);
      exp_xfer = 1'b0;
    end else begin
      check_word("paddr", paddr, ref_pc); // fetch address
      check_bit("pprot[2]", pprot[2], 1'b1);
      check_bit("pwrite", pwrite, 1'b0);
      check_strb("pstrb", pstrb, 4'b0000);
      iss_step(exp_xfer, exp_wr, exp_addr, exp_data, exp_strb);
    end
    check_bit("pprot[1:0] set", |pprot[1:0], 1'b0);
  endtask

  // compare process, samples mid-cycle
  always @(negedge clk) begin
    if (!arst_n) begin
      if (psel !== 1'b0) report_failure("psel high while in reset");
      hold_chk = 1'b0;
    end else begin
      if (hold_chk) begin
        check_word("held paddr", paddr, h_paddr);
        check_word("held pwdata", pwdata, h_pwdata);
        check_strb("held pstrb", pstrb, h_pstrb);
        check_bit("held pwrite", pwrite, h_pwrite);
        check_bit("held psel", psel, h_psel);
        check_bit("held penable", penable, h_pen);
        check_bit("held pprot[2]", pprot[2], h_pprot[2]);
      end
      hold_chk = psel && penable && !pready;
      {h_paddr, h_pwdata, h_pstrb, h_pwrite} = {paddr, pwdata, pstrb, pwrite};
      {h_psel, h_pen, h_pprot} = {psel, penable, pprot};
      if (halted && psel) report_failure("psel raised after halted");
      else if (psel && !penable) check_setup();
    end
  end

  initial begin
    int limit;
    wait (prog.size() > 0);
    limit = 2 * (prog.size() * 5 * 8 + 100); // cycles, both passes
    #(limit * 10);
    $display("watchdog expired before the core halted");
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    arst_n      = 1'b0;
    pready      = 1'b0;
    prdata      = '0;
    random_wait = 1'b0;
    build_program();
    for (int pass = 0; pass < 2; pass++) begin
      @(posedge clk);
      #1;
      arst_n      = 1'b0;
      random_wait = (pass == 1); // second pass with wait states
      load_memories();
      repeat (3) @(posedge clk);
      #1 arst_n = 1'b1;
      wait (halted === 1'b1);
      check_bit("halted", halted, ref_halt);
      repeat (20) @(posedge clk); // psel must stay low meanwhile
    end
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt + fail_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: verilog/rv_alu.sv
`timescale 1ns/10ps

module rv_alu (
  input  rv_core_pkg::word_t   pc,
  input  rv_core_pkg::word_t   rs1_data,
  input  rv_core_pkg::word_t   rs2_data,
  input  rv_core_pkg::word_t   imm,
  input  rv_core_pkg::alu_op_e alu_op,
  input  logic                 use_imm,
  input  logic                 use_pc,
  input  rv_core_pkg::opcode_e opcode,
  input  logic [2:0]           funct3,
  output rv_core_pkg::word_t   result,
  output rv_core_pkg::word_t   next_pc
);

  rv_core_pkg::word_t op_a, op_b;
  rv_core_pkg::word_t sum, diff;
  rv_core_pkg::word_t pc_plus4, pc_target;
  logic               carry;
  logic               zero, overflow, lt, ltu;
  logic [4:0]         shamt;
  logic               taken;

  assign op_a  = use_pc  ? pc  : rs1_data;
  assign op_b  = use_imm ? imm : rs2_data;
  assign shamt = op_b[4:0];

  assign sum = op_a + op_b;

  // one subtractor serves slt and the branch compares
  assign {carry, diff} = {1'b0, op_a} + {1'b0, ~op_b} + 33'd1;
  assign zero     = (diff == '0);
  assign overflow = (op_a[31] != op_b[31]) && (diff[31] != op_a[31]);
  assign lt       = diff[31] ^ overflow;
  assign ltu      = ~carry; // borrow out

  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + imm;

  always_comb begin
    case (alu_op)
      rv_core_pkg::alu_sub:  result = diff;
      rv_core_pkg::alu_sll:  result = op_a << shamt;
      rv_core_pkg::alu_slt:  result = {31'h0, lt};
      rv_core_pkg::alu_sltu: result = {31'h0, ltu};
      rv_core_pkg::alu_xor:  result = op_a ^ op_b;
      rv_core_pkg::alu_srl:  result = op_a >> shamt;
      rv_core_pkg::alu_sra:  result = $signed(op_a) >>> shamt;
      rv_core_pkg::alu_or:   result = op_a | op_b;
      rv_core_pkg::alu_and:  result = op_a & op_b;
      default:               result = sum;
    endcase
    if (opcode == rv_core_pkg::op_jal || opcode == rv_core_pkg::op_jalr)
      result = pc_plus4; // link value
  end

  always_comb begin
    case (funct3)
      3'b000:  taken = zero;  // beq
      3'b001:  taken = ~zero; // bne
      3'b100:  taken = lt;
      3'b101:  taken = ~lt;
      3'b110:  taken = ltu;
      3'b111:  taken = ~ltu;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (opcode == rv_core_pkg::op_jal || (opcode == rv_core_pkg::op_branch && taken))
      next_pc = pc_target;
    else if (opcode == rv_core_pkg::op_jalr)
      next_pc = {sum[31:1], 1'b0}; // rs1 + imm, bit 0 dropped
    else
      next_pc = pc_plus4;
  end

endmodule

// File: verilog/rv_core_pkg.sv
package rv_core_pkg;

  `include "rv_core_settings.svh"

  typedef logic [`RV_XLEN-1:0]   word_t;
  typedef logic [`RV_XLEN/8-1:0] strb_t;     // one bit per byte lane
  typedef logic [`RV_REG_AW-1:0] reg_addr_t;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    op_lui    = 7'b011_0111,
    op_auipc  = 7'b001_0111,
    op_jal    = 7'b110_1111,
    op_jalr   = 7'b110_0111,
    op_branch = 7'b110_0011,
    op_load   = 7'b000_0011,
    op_store  = 7'b010_0011,
    op_imm    = 7'b001_0011,
    op_reg    = 7'b011_0011,
    op_system = 7'b111_0011
  } opcode_e;

  // core sequencing
  typedef enum logic [1:0] {
    st_fetch = 2'd0, // instruction read over apb
    st_exec  = 2'd1,
    st_mem   = 2'd2, // data read or write over apb
    st_halt  = 2'd3
  } state_e;

  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_sll  = 4'd2,
    alu_slt  = 4'd3,
    alu_sltu = 4'd4,
    alu_xor  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_or   = 4'd8,
    alu_and  = 4'd9
  } alu_op_e;

endpackage

// File: verilog/rv_core_settings.svh
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// data and address width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_NREGS 32

// bits needed to index the register file
`define RV_REG_AW 5

// first fetch address after reset
`define RV_RESET_VECTOR 32'h8000_0000

`endif

// File: verilog/rv_core_top.sv
`timescale 1ns/10ps

module rv_core_top (
  input  logic               clk,
  input  logic               arst_n,
  output rv_core_pkg::word_t paddr,
  output logic               psel,
  output logic               penable,
  output logic               pwrite,
  output rv_core_pkg::word_t pwdata,
  output rv_core_pkg::strb_t pstrb,
  output logic [2:0]         pprot,
  input  rv_core_pkg::word_t prdata,
  input  logic               pready,
  output logic               halted
);

  rv_core_pkg::word_t     inst, pc, next_pc, imm;
  rv_core_pkg::word_t     rs1_data, rs2_data, result, wdata;
  rv_core_pkg::word_t     store_data, load_word, load_data;
  rv_core_pkg::strb_t     store_strb;
  rv_core_pkg::reg_addr_t rs1, rs2, rd;
  rv_core_pkg::opcode_e   opcode;
  rv_core_pkg::alu_op_e   alu_op;
  logic [2:0]             funct3;
  logic [1:0]             wb_sel;
  logic                   use_imm, use_pc, reg_write, retire;
  logic                   is_mem, is_store, is_halt;

  rv_ctrl_fsm i_fsm (
    .clk, .arst_n, .paddr, .psel, .penable, .pwrite, .pwdata, .pstrb, .pprot,
    .prdata, .pready, .halted, .inst, .pc, .retire, .is_mem, .is_store, .is_halt,
    .mem_addr(result), .store_data, .store_strb, .load_word, .next_pc
  );

  rv_decoder i_decoder (
    .inst, .rs1, .rs2, .rd, .funct3, .opcode, .imm, .alu_op, .use_imm, .use_pc,
    .reg_write, .wb_sel, .is_mem, .is_store, .is_halt
  );

  rv_regfile i_regfile (
    .clk, .rs1, .rs2, .rd,
    .wen(reg_write & retire), // only on the retiring cycle
    .wdata, .rs1_data, .rs2_data
  );

  rv_alu i_alu (
    .pc, .rs1_data, .rs2_data, .imm, .alu_op, .use_imm, .use_pc, .opcode, .funct3,
    .result, .next_pc
  );

  rv_lsu i_lsu (
    .mem_addr(result), .funct3, .rs2_data, .load_word, .store_data, .store_strb,
    .load_data
  );

  // write-back source, lui takes the immediate as is
  assign wdata = (wb_sel == 2'd1) ? load_data :
                 (wb_sel == 2'd2) ? imm : result;

endmodule

// File: verilog/rv_ctrl_fsm.sv
`timescale 1ns/10ps

`include "rv_core_settings.svh"

module rv_ctrl_fsm (
  input  logic               clk,
  input  logic               arst_n,
  output rv_core_pkg::word_t paddr,
  output logic               psel,
  output logic               penable,
  output logic               pwrite,
  output rv_core_pkg::word_t pwdata,
  output rv_core_pkg::strb_t pstrb,
  output logic [2:0]         pprot,
  input  rv_core_pkg::word_t prdata,
  input  logic               pready,
  output logic               halted,
  output rv_core_pkg::word_t inst,
  output rv_core_pkg::word_t pc,
  output logic               retire,
  input  logic               is_mem,
  input  logic               is_store,
  input  logic               is_halt,
  input  rv_core_pkg::word_t mem_addr,
  input  rv_core_pkg::word_t store_data,
  input  rv_core_pkg::strb_t store_strb,
  output rv_core_pkg::word_t load_word,
  input  rv_core_pkg::word_t next_pc
);

  rv_core_pkg::state_e state;
  rv_core_pkg::word_t  load_q;
  logic                xfer_done;
  logic                data_done;

  assign xfer_done = psel && penable && pready;
  assign data_done = (state == rv_core_pkg::st_mem) && xfer_done;

  assign retire = data_done ||
                  (state == rv_core_pkg::st_exec && !is_mem && !is_halt);

  // the load retires on the pready edge, so pass prdata straight through then
  assign load_word = data_done ? prdata : load_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= rv_core_pkg::st_fetch;
      pc      <= `RV_RESET_VECTOR;
      paddr   <= `RV_RESET_VECTOR;
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      pstrb   <= '0;
      pprot   <= 3'b100;
      halted  <= 1'b0;
    end else begin
      case (state)
        rv_core_pkg::st_fetch: begin
          if (!psel) begin // first fetch after reset
            psel  <= 1'b1;
            paddr <= pc;
          end else if (!penable) begin
            penable <= 1'b1;
          end else if (pready) begin
            psel    <= 1'b0;
            penable <= 1'b0;
            state   <= rv_core_pkg::st_exec;
          end
        end
        rv_core_pkg::st_exec: begin
          psel <= !is_halt;
          if (is_halt) begin
            halted <= 1'b1;
            state  <= rv_core_pkg::st_halt;
          end else if (is_mem) begin
            paddr  <= {mem_addr[31:2], 2'b00};
            pwrite <= is_store;
            pstrb  <= is_store ? store_strb : '0;
            pprot  <= 3'b000; // data access
            state  <= rv_core_pkg::st_mem;
          end else begin
            pc    <= next_pc;
            paddr <= next_pc;
            state <= rv_core_pkg::st_fetch;
          end
        end
        rv_core_pkg::st_mem: begin
          if (!penable) begin
            penable <= 1'b1;
          end else if (pready) begin
            penable <= 1'b0; // psel stays up for the next fetch setup
            pc      <= next_pc;
            paddr   <= next_pc;
            pwrite  <= 1'b0;
            pstrb   <= '0;
            pprot   <= 3'b100;
            state   <= rv_core_pkg::st_fetch;
          end
        end
        default: ; // st_halt, parked for good
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == rv_core_pkg::st_exec && is_mem) pwdata <= store_data;
    if (xfer_done) begin
      if (state == rv_core_pkg::st_mem) load_q <= prdata;
      else inst <= prdata;
    end
  end

endmodule

// File: verilog/rv_decoder.sv
`timescale 1ns/10ps

module rv_decoder (
  input  rv_core_pkg::word_t     inst,
  output rv_core_pkg::reg_addr_t rs1,
  output rv_core_pkg::reg_addr_t rs2,
  output rv_core_pkg::reg_addr_t rd,
  output logic [2:0]             funct3,
  output rv_core_pkg::opcode_e   opcode,
  output rv_core_pkg::word_t     imm,
  output rv_core_pkg::alu_op_e   alu_op,
  output logic                   use_imm,
  output logic                   use_pc,
  output logic                   reg_write,
  output logic [1:0]             wb_sel,
  output logic                   is_mem,
  output logic                   is_store,
  output logic                   is_halt
);

  rv_core_pkg::word_t    imm_i, imm_s, imm_b, imm_u, imm_j;
  rv_core_pkg::alu_op_e  func_op;
  logic                  is_shift;

  assign opcode = rv_core_pkg::opcode_e'(inst[6:0]);
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101); // slli, srli, srai

  // funct3 picks the operation, inst[30] splits add/sub and srl/sra
  always_comb begin
    case (funct3)
      3'b000:  func_op = (opcode == rv_core_pkg::op_reg && inst[30]) ?
                         rv_core_pkg::alu_sub : rv_core_pkg::alu_add;
      3'b001:  func_op = rv_core_pkg::alu_sll;
      3'b010:  func_op = rv_core_pkg::alu_slt;
      3'b011:  func_op = rv_core_pkg::alu_sltu;
      3'b100:  func_op = rv_core_pkg::alu_xor;
      3'b101:  func_op = inst[30] ? rv_core_pkg::alu_sra : rv_core_pkg::alu_srl;
      3'b110:  func_op = rv_core_pkg::alu_or;
      default: func_op = rv_core_pkg::alu_and;
    endcase
  end

  // wb_sel: 0 alu result, 1 load data, 2 immediate
  always_comb begin
    imm       = '0;
    alu_op    = rv_core_pkg::alu_add;
    use_imm   = 1'b0;
    use_pc    = 1'b0;
    reg_write = 1'b0;
    wb_sel    = 2'd0;
    is_mem    = 1'b0;
    is_store  = 1'b0;
    is_halt   = 1'b0;
    case (opcode)
      rv_core_pkg::op_lui: begin
        imm       = imm_u;
        reg_write = 1'b1;
        wb_sel    = 2'd2;
      end
      rv_core_pkg::op_auipc: begin
        imm       = imm_u;
        use_imm   = 1'b1;
        use_pc    = 1'b1;
        reg_write = 1'b1;
      end
      rv_core_pkg::op_jal: begin
        imm       = imm_j;
        reg_write = 1'b1; // link comes out of the alu
      end
      rv_core_pkg::op_jalr: begin
        imm       = imm_i;
        use_imm   = 1'b1;
        reg_write = 1'b1;
      end
      rv_core_pkg::op_branch: begin
        imm    = imm_b;
        alu_op = rv_core_pkg::alu_sub;
      end
      rv_core_pkg::op_load: begin
        imm       = imm_i;
        use_imm   = 1'b1;
        reg_write = 1'b1;
        wb_sel    = 2'd1;
        is_mem    = 1'b1;
      end
      rv_core_pkg::op_store: begin
        imm      = imm_s;
        use_imm  = 1'b1;
        is_mem   = 1'b1;
        is_store = 1'b1;
      end
      rv_core_pkg::op_imm: begin
        imm       = is_shift ? {27'h0, inst[24:20]} : imm_i; // shamt form for shifts
        use_imm   = 1'b1;
        reg_write = 1'b1;
        alu_op    = func_op;
      end
      rv_core_pkg::op_reg: begin
        reg_write = 1'b1;
        alu_op    = func_op;
      end
      rv_core_pkg::op_system: is_halt = 1'b1;
      default: ; // unknown opcode, no write and pc + 4
    endcase
  end

endmodule

// File: verilog/rv_lsu.sv
`timescale 1ns/10ps

module rv_lsu (
  input  rv_core_pkg::word_t mem_addr,
  input  logic [2:0]         funct3,
  input  rv_core_pkg::word_t rs2_data,
  input  rv_core_pkg::word_t load_word,
  output rv_core_pkg::word_t store_data,
  output rv_core_pkg::strb_t store_strb,
  output rv_core_pkg::word_t load_data
);

  logic [7:0]  load_byte;
  logic [15:0] load_half;

  // store side, replicate into every lane and let the strobes pick
  always_comb begin
    case (funct3[1:0])
      2'b00: begin // sb
        store_data = {4{rs2_data[7:0]}};
        store_strb = 4'b0001 << mem_addr[1:0];
      end
      2'b01: begin // sh
        store_data = {2{rs2_data[15:0]}};
        store_strb = mem_addr[1] ? 4'b1100 : 4'b0011;
      end
      2'b10: begin
        store_data = rs2_data;
        store_strb = 4'b1111;
      end
      default: begin
        store_data = rs2_data;
        store_strb = 4'b0000;
      end
    endcase
  end

  // load side
  always_comb begin
    case (mem_addr[1:0])
      2'b00:   load_byte = load_word[7:0];
      2'b01:   load_byte = load_word[15:8];
      2'b10:   load_byte = load_word[23:16];
      default: load_byte = load_word[31:24];
    endcase
  end

  assign load_half = mem_addr[1] ? load_word[31:16] : load_word[15:0];

  always_comb begin
    case (funct3)
      3'b000:  load_data = {{24{load_byte[7]}}, load_byte};  // lb
      3'b001:  load_data = {{16{load_half[15]}}, load_half}; // lh
      3'b100:  load_data = {24'h0, load_byte};
      3'b101:  load_data = {16'h0, load_half};
      default: load_data = load_word; // lw
    endcase
  end

endmodule

// File: verilog/rv_regfile.sv
`timescale 1ns/10ps

`include "rv_core_settings.svh"

module rv_regfile (
  input  logic                   clk,
  input  rv_core_pkg::reg_addr_t rs1,
  input  rv_core_pkg::reg_addr_t rs2,
  input  rv_core_pkg::reg_addr_t rd,
  input  logic                   wen,
  input  rv_core_pkg::word_t     wdata,
  output rv_core_pkg::word_t     rs1_data,
  output rv_core_pkg::word_t     rs2_data
);

  // x1..x31 only, x0 has no storage
  rv_core_pkg::word_t regs [1:`RV_NREGS-1];

  always_ff @(posedge clk) begin
    if (wen && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule
